// ==== sources.f ====
logic/trackerCfgPkg.sv
logic/wbMapPkg.sv
logic/trackerIfs.sv
logic/slotHeap.sv
logic/completionTimers.sv
logic/retireSequencer.sv
logic/completionFifo.sv
logic/wbSlaveCtrl.sv
logic/cmdTracker.sv
tb/tbChecker.sv
tb/tbTop.sv

// ==== Makefile ====
# Verilator build for the command tracker testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tbTop
RTL_TOP   ?= cmdTracker
BUILD_DIR ?= obj_dir
SIM_BIN   ?= simv
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) \
		logic/trackerCfgPkg.sv logic/wbMapPkg.sv logic/trackerIfs.sv \
		logic/slotHeap.sv logic/completionTimers.sv logic/retireSequencer.sv \
		logic/completionFifo.sv logic/wbSlaveCtrl.sv logic/cmdTracker.sv
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary -j 0 -Wno-fatal $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tbTop.sv ====
// Testbench top for the command tracker
// Runs reset, tag, drain, ordering and back-pressure tests over Wishbone
// Expected completion words are handed to tbChecker for comparing
module tbTop;
    timeunit 1ns;
    timeprecision 1ps;

    import wbMapPkg::*;

    localparam int N_ENTRIES = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int BATCHES = 4;
    localparam int BATCH_LEN = 8;
    // More commands than slots, few enough that the FIFO plus heap can hold them
    localparam int FLOOD_LEN = N_ENTRIES + FIFO_DEPTH / 2;
    localparam int TOTAL_CMDS = BATCHES * BATCH_LEN + 2 + FLOOD_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_CMDS * (16 + N_ENTRIES) * 10 + 2000;
    // notFull set and level zero
    localparam logic [31:0] IDLE_STATUS = 32'h0000_0001;
    // Latency 16 and latency 1
    localparam logic [23:0] SLOW_PAYLOAD = 24'h5A5A5F;
    localparam logic [23:0] FAST_PAYLOAD = 24'h3C3C30;

    logic        clk;
    logic        reset_n;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [3:0]  wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic        wbAck;

    // Checker control
    int          testId;
    logic        ordered;
    logic        needEmpty;
    logic        addExp;
    logic [31:0] expWord;
    int          pendingCount;
    int          errorCount;
    int          checkedCount;

    int          nextTag;
    int          sentCount;
    int          seedValue;
    logic [31:0] rdata;
    logic [31:0] slowWord;
    logic [31:0] fastWord;

    cmdTracker #(.N_ENTRIES(N_ENTRIES), .MIN_FREE_SLOTS(1), .N_OUTPUT_REG_STAGES(0),
        .FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk, .reset_n, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck
    );

    tbChecker compChk (
        .clk, .reset_n, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatR, .wbAck,
        .testId, .ordered, .needEmpty, .statusExp(IDLE_STATUS), .addExp, .expWord,
        .pendingCount, .errorCount, .checkedCount
    );

    always #4 clk = ~clk;

    // Completion word: valid, spare zero, round robin tag, payload
    function automatic logic [31:0] refWord(input int tag, input logic [23:0] payload);
        return {1'b1, 1'b0, 6'(tag), payload};
    endfunction

    // ========================================
    // Bus tasks
    // ========================================

    // One classic cycle, signals held until ack, which is sampled mid cycle
    task automatic busCycle(input logic we, input logic [3:0] adr, input logic [31:0] data,
        output logic [31:0] result);
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= we;
        wbAdr <= adr;
        wbDatW <= data;
        do
        begin
            @(negedge clk);
        end
        while (!wbAck);
        result = wbDatR;
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
    endtask

    task automatic pushExpect(input logic [31:0] word);
        @(posedge clk);
        addExp <= 1'b1;
        expWord <= word;
        @(posedge clk);
        addExp <= 1'b0;
    endtask

    // Write a command and queue its predicted completion
    task automatic sendCmd(input logic [23:0] payload);
        logic [31:0] word;
        logic [31:0] ignored;
        word = refWord(nextTag, payload);
        busCycle(1'b1, regCmd, {8'd0, payload}, ignored);
        nextTag = (nextTag + 1) % N_ENTRIES;
        sentCount++;
        pushExpect(word);
    endtask

    task automatic startTest(input int id, input logic inOrder, input logic emptyOnly);
        @(posedge clk);
        testId <= id;
        ordered <= inOrder;
        needEmpty <= emptyOnly;
    endtask

    // Pop until every queued completion has been seen
    task automatic drainAll();
        logic [31:0] ignored;
        @(posedge clk);
        while (pendingCount != 0)
        begin
            busCycle(1'b0, regCompl, '0, ignored);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        testId = 0;
        ordered = 1'b0;
        needEmpty = 1'b0;
        addExp = 1'b0;
        expWord = '0;
        nextTag = 0;
        sentCount = 0;
        seedValue = $urandom(32'h658);
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        // Idle status and empty FIFO after reset
        startTest(1, 1'b0, 1'b1);
        busCycle(1'b0, regStatus, '0, rdata);
        busCycle(1'b0, regCompl, '0, rdata);

        // Random payloads in batches, drained after each
        startTest(2, 1'b0, 1'b0);
        for (int b = 0; b < BATCHES; b++)
        begin
            for (int i = 0; i < BATCH_LEN; i++)
            begin
                sendCmd(24'($urandom));
            end
            drainAll();
        end

        // Nothing left once drained
        startTest(3, 1'b0, 1'b1);
        busCycle(1'b0, regCompl, '0, rdata);
        busCycle(1'b0, regStatus, '0, rdata);

        // Slow command then fast command, fast one must pop first
        startTest(4, 1'b1, 1'b0);
        slowWord = refWord(nextTag, SLOW_PAYLOAD);
        busCycle(1'b1, regCmd, {8'd0, SLOW_PAYLOAD}, rdata);
        nextTag = (nextTag + 1) % N_ENTRIES;
        fastWord = refWord(nextTag, FAST_PAYLOAD);
        busCycle(1'b1, regCmd, {8'd0, FAST_PAYLOAD}, rdata);
        nextTag = (nextTag + 1) % N_ENTRIES;
        sentCount += 2;
        pushExpect(fastWord);
        pushExpect(slowWord);
        drainAll();

        // No pops while flooding with maximum latency
        startTest(5, 1'b0, 1'b0);
        for (int i = 0; i < FLOOD_LEN; i++)
        begin
            sendCmd({20'($urandom), 4'hF});
        end
        drainAll();
        startTest(5, 1'b0, 1'b1);
        busCycle(1'b0, regCompl, '0, rdata);
        busCycle(1'b0, regStatus, '0, rdata);

        repeat (4) @(posedge clk);
        $display("Errors %0d, completions checked %0d of %0d sent",
            errorCount, checkedCount, sentCount);
        if (errorCount == 0 && checkedCount == sentCount)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Ends a hung run
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== tb/tbChecker.sv ====
// Watches the Wishbone port of the tracker and checks every acked read
// COMPL words are matched against expected words queued by tbTop
// STATUS words are compared against the expected idle status
module tbChecker
(
    input  logic clk,
    input  logic reset_n,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [wbMapPkg::WB_ADDR_BITS-1:0] wbAdr,
    input  logic [wbMapPkg::WB_DATA_BITS-1:0] wbDatR,
    input  logic wbAck,
    input  int   testId,
    input  logic ordered,
    input  logic needEmpty,
    input  logic [wbMapPkg::WB_DATA_BITS-1:0] statusExp,
    input  logic addExp,
    input  logic [wbMapPkg::WB_DATA_BITS-1:0] expWord,
    output int   pendingCount,
    output int   errorCount,
    output int   checkedCount
);
    timeunit 1ns;
    timeprecision 1ps;

    import wbMapPkg::*;

    // Completion words still owed by the DUT
    logic [WB_DATA_BITS-1:0] pending [$];
    int pendingNow = 0;
    int errors = 0;
    int checked = 0;

    assign pendingCount = pendingNow;
    assign errorCount = errors;
    assign checkedCount = checked;

    function automatic string testName(input int id);
        case (id)
            1: return "reset";
            2: return "tags";
            3: return "drain";
            4: return "order";
            5: return "backpressure";
            default: return "none";
        endcase
    endfunction

    // ========================================
    // COMPL word check
    // ========================================

    // valid 31, tag 29:24, payload 23:0
    task automatic checkCompl(input logic [WB_DATA_BITS-1:0] actual);
        int hit;
        hit = -1;
        if (actual[31] == 1'b0)
        begin
            // FIFO was empty, nothing popped
        end
        else if (needEmpty)
        begin
            $display("error %s expected %h actual %h", testName(testId), 32'h0, actual);
            errors++;
        end
        else
        begin
            // Ordered tests take the head, others the oldest entry with the same tag
            if (ordered && pending.size() > 0)
            begin
                hit = 0;
            end
            for (int i = 0; i < pending.size() && !ordered; i++)
            begin
                if (hit < 0 && pending[i][29:24] == actual[29:24])
                begin
                    hit = i;
                end
            end
            if (hit < 0)
            begin
                $display("Test %s popped completion %h with an unknown tag or a second time",
                    testName(testId), actual);
                errors++;
            end
            else
            begin
                if (pending[hit] !== actual)
                begin
                    $display("error %s expected %h actual %h", testName(testId),
                        pending[hit], actual);
                    errors++;
                end
                pending.delete(hit);
                checked++;
            end
        end
    endtask

    // ========================================
    // Bus watcher
    // ========================================

    // Sampled values at the edge that ends the ack cycle
    always @(posedge clk)
    begin
        if (addExp)
        begin
            pending.push_back(expWord);
        end
        // One ack per strobe, never one without a strobe
        if (reset_n && wbAck && !(wbCyc && wbStb))
        begin
            $display("Test %s saw an ack with no strobe pending", testName(testId));
            errors++;
        end
        if (reset_n && wbCyc && wbStb && wbAck && !wbWe)
        begin
            if (wbAdr == regStatus && wbDatR !== statusExp)
            begin
                $display("error %s expected %h actual %h", testName(testId), statusExp, wbDatR);
                errors++;
            end
            else if (wbAdr == regCompl)
            begin
                checkCompl(wbDatR);
            end
        end
        pendingNow <= pending.size();
    end

endmodule

// ==== logic/cmdTracker.sv ====
// Top level of the tagged command tracker
// Host side is a plain Wishbone classic slave port
// Set the slot count, heap read stages and FIFO depth here
module cmdTracker
#(
    parameter int N_ENTRIES = 16,
    parameter int MIN_FREE_SLOTS = 1,
    parameter int N_OUTPUT_REG_STAGES = 0,
    parameter int FIFO_DEPTH = 8
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [wbMapPkg::WB_ADDR_BITS-1:0] wbAdr,
    input  logic [wbMapPkg::WB_DATA_BITS-1:0] wbDatW,
    output logic [wbMapPkg::WB_DATA_BITS-1:0] wbDatR,
    output logic wbAck
);
    import trackerCfgPkg::*;

    allocIf  allocBus ();
    retireIf retireBus ();

    // Expiry handshake
    logic     expValid;
    slotIdx_t expIdx;
    logic     expTake;

    // Completion FIFO
    logic                  push;
    complRec_t             pushRec;
    logic                  pop;
    complRec_t             popRec;
    logic                  empty;
    logic                  full;
    logic [LEVEL_BITS-1:0] level;

    wbSlaveCtrl ctrl (
        .clk, .reset_n,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
        .alloc(allocBus.ctrl),
        .pop, .popRec, .empty, .level
    );

    slotHeap #(
        .N_ENTRIES(N_ENTRIES),
        .MIN_FREE_SLOTS(MIN_FREE_SLOTS),
        .N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)
    ) heap (
        .clk, .reset_n,
        .alloc(allocBus.heap),
        .retire(retireBus.heap)
    );

    completionTimers #(.N_ENTRIES(N_ENTRIES)) timers (
        .clk, .reset_n,
        .alloc(allocBus.monitor),
        .expValid, .expIdx, .expTake
    );

    retireSequencer #(.N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)) retireSeq (
        .clk, .reset_n,
        .expValid, .expIdx, .expTake,
        .retire(retireBus.seq),
        .push, .pushRec, .full
    );

    completionFifo #(.FIFO_DEPTH(FIFO_DEPTH)) complFifo (
        .clk, .reset_n,
        .push, .pushRec, .pop, .popRec, .empty, .full, .level
    );

endmodule

// ==== logic/wbSlaveCtrl.sv ====
// Wishbone classic slave decoding CMD, STATUS and COMPL
// CMD writes wait for a free slot then enqueue, reads return in two cycles
// COMPL reads pop one record when the FIFO holds one
module wbSlaveCtrl
(
    input  logic clk,
    input  logic reset_n,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [wbMapPkg::WB_ADDR_BITS-1:0] wbAdr,
    input  logic [wbMapPkg::WB_DATA_BITS-1:0] wbDatW,
    output logic [wbMapPkg::WB_DATA_BITS-1:0] wbDatR,
    output logic wbAck,
    allocIf.ctrl alloc,
    output logic pop,
    input  trackerCfgPkg::complRec_t popRec,
    input  logic empty,
    input  logic [trackerCfgPkg::LEVEL_BITS-1:0] level
);
    import trackerCfgPkg::*;
    import wbMapPkg::*;

    wbState_e state;
    regAddr_e adr;
    logic     isCmdWrite;
    logic     isComplRead;

    // Master holds address and data until ack
    assign adr = regAddr_e'(wbAdr);
    assign isCmdWrite = wbWe && (adr == regCmd);
    assign isComplRead = !wbWe && (adr == regCompl);

    assign alloc.enq = (state == wsAlloc) && alloc.notFull;
    assign alloc.enqData = wbDatW[PAYLOAD_BITS-1:0];
    assign pop = (state == wsReadOut) && isComplRead && !empty;
    assign wbAck = (state == wsAck);

    // ========================================
    // Bus FSM
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= wsIdle;
        end
        else
        begin
            case (state)
                wsIdle:
                begin
                    if (wbCyc && wbStb)
                    begin
                        state <= isCmdWrite ? wsAlloc : wsReadOut;
                    end
                end
                // Ack may wait here while the heap is full
                wsAlloc:
                begin
                    if (alloc.notFull)
                    begin
                        state <= wsAck;
                    end
                end
                wsReadOut: state <= wsAck;
                wsAck: state <= wsIdle;
                default: state <= wsIdle;
            endcase
        end
    end

    // Read data captured one cycle ahead of the ack
    always_ff @(posedge clk)
    begin
        if (state == wsReadOut)
        begin
            case (adr)
                regStatus: wbDatR <= {16'd0, level, 7'd0, alloc.notFull};
                // valid 31, spare 30, tag 29:24, payload 23:0
                regCompl:
                begin
                    wbDatR <= empty ? '0 : {popRec.valid, 1'b0, popRec.tag, popRec.payload};
                end
                default: wbDatR <= '0;
            endcase
        end
    end

endmodule

// ==== logic/completionFifo.sv ====
// Circular FIFO of completion records between retire path and host
// popRec always shows the head entry, level is the current fill count
module completionFifo
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic push,
    input  trackerCfgPkg::complRec_t pushRec,
    input  logic pop,
    output trackerCfgPkg::complRec_t popRec,
    output logic empty,
    output logic full,
    output logic [trackerCfgPkg::LEVEL_BITS-1:0] level
);
    import trackerCfgPkg::*;

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    complRec_t           store [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;

    assign popRec = store[rdPtr];
    assign empty = (level == '0);
    assign full = (level == LEVEL_BITS'(FIFO_DEPTH));

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            store[wrPtr] <= pushRec;
        end
    end

    // Pointers wrap at FIFO_DEPTH, which need not be a power of two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= (wrPtr == PTR_BITS'(FIFO_DEPTH-1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop)
            begin
                rdPtr <= (rdPtr == PTR_BITS'(FIFO_DEPTH-1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

// ==== logic/retireSequencer.sv ====
// Retires one expired slot at a time
// Takes the slot, reads its payload from the heap, then frees the slot
// and pushes the completion record in the same cycle
module retireSequencer
#(
    parameter int N_OUTPUT_REG_STAGES = 0
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic expValid,
    input  trackerCfgPkg::slotIdx_t expIdx,
    output logic expTake,
    retireIf.seq retire,
    output logic push,
    output trackerCfgPkg::complRec_t pushRec,
    input  logic full
);
    import trackerCfgPkg::*;

    localparam int WAIT_BITS = (N_OUTPUT_REG_STAGES > 0) ? $clog2(N_OUTPUT_REG_STAGES + 1) : 1;

    retireState_e         state;
    slotIdx_t             heldIdx;
    logic [WAIT_BITS-1:0] waitCnt;

    assign expTake = (state == rsIdle) && expValid;
    // Held index addresses both the read and the free
    assign retire.readReq = heldIdx;
    assign retire.freeIdx = heldIdx;
    // Stall here while the FIFO is full
    assign push = (state == rsPush) && !full;
    assign retire.free = push;

    assign pushRec.valid = 1'b1;
    assign pushRec.tag = heldIdx;
    assign pushRec.payload = retire.readRsp;

    always_ff @(posedge clk)
    begin
        if (expTake)
        begin
            heldIdx <= expIdx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= rsIdle;
            waitCnt <= '0;
        end
        else
        begin
            case (state)
                rsIdle:
                begin
                    if (expValid)
                    begin
                        state <= rsRead;
                    end
                end
                rsRead:
                begin
                    waitCnt <= WAIT_BITS'(N_OUTPUT_REG_STAGES);
                    state <= rsWait;
                end
                // Zero count means readRsp is valid now
                rsWait:
                begin
                    if (waitCnt == '0)
                    begin
                        state <= rsPush;
                    end
                    else
                    begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                rsPush:
                begin
                    if (!full)
                    begin
                        state <= rsIdle;
                    end
                end
                default: state <= rsIdle;
            endcase
        end
    end

endmodule

// ==== logic/completionTimers.sv ====
// One countdown per slot modelling backend latency
// Loads on allocation with the payload latency field, then counts down
// Presents the lowest expired slot and holds it until expTake
module completionTimers
#(
    parameter int N_ENTRIES = 16
)
(
    input  logic clk,
    input  logic reset_n,
    allocIf.monitor alloc,
    output logic expValid,
    output trackerCfgPkg::slotIdx_t expIdx,
    input  logic expTake
);
    import trackerCfgPkg::*;

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    logic [LAT_BITS-1:0]  count [N_ENTRIES];
    logic [N_ENTRIES-1:0] active;
    logic [N_ENTRIES-1:0] expired;
    logic                 anyExpired;
    slotIdx_t             firstExpired;

    // Priority pick, scanning down so the lowest index wins
    always_comb
    begin
        anyExpired = 1'b0;
        firstExpired = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--)
        begin
            expired[i] = active[i] && (count[i] == '0);
            if (expired[i])
            begin
                anyExpired = 1'b1;
                firstExpired = slotIdx_t'(i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            active <= '0;
            expValid <= 1'b0;
            expIdx <= '0;
            for (int i = 0; i < N_ENTRIES; i++)
            begin
                count[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < N_ENTRIES; i++)
            begin
                if (active[i] && (count[i] != '0))
                begin
                    count[i] <= count[i] - 1'b1;
                end
            end
            // Taken slot goes idle, a new pick follows a cycle later
            if (expTake)
            begin
                active[expIdx[IDX_BITS-1:0]] <= 1'b0;
                expValid <= 1'b0;
            end
            else if (!expValid && anyExpired)
            begin
                expValid <= 1'b1;
                expIdx <= firstExpired;
            end
            // Count holds latency minus one
            if (alloc.enq)
            begin
                active[alloc.allocIdx[IDX_BITS-1:0]] <= 1'b1;
                count[alloc.allocIdx[IDX_BITS-1:0]] <= alloc.enqData[LAT_BITS-1:0];
            end
        end
    end

endmodule

// ==== logic/slotHeap.sv ====
// Round robin slot heap holding one command payload per slot
// Payload is written when the slot is allocated and read back on retire
// notFull looks MIN_FREE_SLOTS+2 slots ahead and lags the busy flags by two
module slotHeap
#(
    parameter int N_ENTRIES = 16,
    parameter int MIN_FREE_SLOTS = 1,
    parameter int N_OUTPUT_REG_STAGES = 0
)
(
    input  logic clk,
    input  logic reset_n,
    allocIf.heap alloc,
    retireIf.heap retire
);
    import trackerCfgPkg::*;

    localparam int IDX_BITS = $clog2(N_ENTRIES);
    // Two extra slots cover the two cycle notFull pipeline
    localparam int MIN_FREE_Q = MIN_FREE_SLOTS + 2;

    logic [N_ENTRIES-1:0]            notBusy;
    logic [IDX_BITS-1:0]             nextAlloc;
    logic [MIN_FREE_Q+N_ENTRIES-1:0] notBusyRepl;
    logic [MIN_FREE_Q-1:0]           checkBits;

    logic [PAYLOAD_BITS-1:0] mem [N_ENTRIES];
    logic [PAYLOAD_BITS-1:0] rdStage [N_OUTPUT_REG_STAGES+1];

    assign alloc.allocIdx = slotIdx_t'(nextAlloc);

    // ========================================
    // Allocation and full detection
    // ========================================

    // Low flags repeated past the top so the window never wraps
    assign notBusyRepl = {notBusy[MIN_FREE_Q-1:0], notBusy};

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            checkBits <= '0;
            alloc.notFull <= 1'b0;
        end
        else
        begin
            checkBits <= notBusyRepl[nextAlloc +: MIN_FREE_Q];
            alloc.notFull <= &checkBits;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            nextAlloc <= '0;
        end
        else if (alloc.enq)
        begin
            nextAlloc <= (nextAlloc == IDX_BITS'(N_ENTRIES-1)) ? '0 : nextAlloc + 1'b1;
        end
    end

    // Busy flags, cleared on enq and set again on free
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            notBusy <= '1;
        end
        else
        begin
            if (alloc.enq)
            begin
                notBusy[nextAlloc] <= 1'b0;
            end
            if (retire.free)
            begin
                notBusy[retire.freeIdx[IDX_BITS-1:0]] <= 1'b1;
            end
        end
    end

    // ========================================
    // Payload memory
    // ========================================

    always_ff @(posedge clk)
    begin
        if (alloc.enq)
        begin
            mem[nextAlloc] <= alloc.enqData;
        end
        // Data one cycle after the request, then the extra stages
        rdStage[0] <= mem[retire.readReq[IDX_BITS-1:0]];
        for (int s = 0; s < N_OUTPUT_REG_STAGES; s++)
        begin
            rdStage[s+1] <= rdStage[s];
        end
    end

    assign retire.readRsp = rdStage[N_OUTPUT_REG_STAGES];

endmodule

// ==== logic/trackerIfs.sv ====
// Internal bundles of the tracker
// allocIf joins the Wishbone controller, heap and timers on allocation
// retireIf joins the retire sequencer to the heap read and free port

interface allocIf;
    import trackerCfgPkg::*;

    logic                    enq;
    logic [PAYLOAD_BITS-1:0] enqData;
    logic                    notFull;
    slotIdx_t                allocIdx;

    // Controller requests a slot
    modport ctrl (output enq, enqData, input notFull);
    // Heap owns the slot pointer and the full state
    modport heap (input enq, enqData, output notFull, allocIdx);
    // Timers only snoop the allocation
    modport monitor (input enq, enqData, allocIdx);
endinterface

interface retireIf;
    import trackerCfgPkg::*;

    slotIdx_t                readReq;
    logic [PAYLOAD_BITS-1:0] readRsp;
    logic                    free;
    slotIdx_t                freeIdx;

    modport seq (output readReq, free, freeIdx, input readRsp);
    modport heap (input readReq, free, freeIdx, output readRsp);
endinterface

// ==== logic/wbMapPkg.sv ====
// Wishbone bus widths, register map and slave controller states
// Imported by the Wishbone controller and used by name at the top level
package wbMapPkg;

    localparam int WB_ADDR_BITS = 4;
    localparam int WB_DATA_BITS = 32;

    // Word addresses of the host visible registers
    typedef enum logic [WB_ADDR_BITS-1:0] {
        regCmd    = 4'd0,
        regStatus = 4'd1,
        regCompl  = 4'd2
    } regAddr_e;

    // Slave controller FSM
    typedef enum logic [1:0] {
        wsIdle,
        wsAlloc,
        wsReadOut,
        wsAck
    } wbState_e;

endpackage

// ==== logic/trackerCfgPkg.sv ====
// Widths, record layout and retire states shared by the tracker datapath
// Imported by the heap, timers, retire sequencer, FIFO and Wishbone controller
package trackerCfgPkg;

    // Command payload and heap data width
    localparam int PAYLOAD_BITS = 24;
    // Tag field width in a completion record
    // Slot count must stay at or below 2**TAG_BITS
    localparam int TAG_BITS = 6;
    // Low payload field that selects latency (field plus one cycles)
    localparam int LAT_BITS = 4;
    // FIFO fill level width as reported in STATUS
    localparam int LEVEL_BITS = 8;

    // Slot indices travel at tag width
    typedef logic [TAG_BITS-1:0] slotIdx_t;

    // Completion record as stored in the FIFO
    typedef struct packed {
        logic                    valid;
        slotIdx_t                tag;
        logic [PAYLOAD_BITS-1:0] payload;
    } complRec_t;

    typedef enum logic [1:0] {
        rsIdle,
        rsRead,
        rsWait,
        rsPush
    } retireState_e;

endpackage
